//--- build.f
cachePkg.sv
metaDataArray.sv
dataArray.sv
cacheController.sv
cacheTop.sv
tbCache.sv

//--- cacheController.sv
// access FSM for the two-way write-through cache
// Idle latches a request, Compare looks it up in the metadata array
// a read miss goes FillReq, FillWait (8 words into the victim way), FillMeta and back to Compare
// writes go to WriteThru and wait for memWrDone
// a write miss allocates nothing
// done, hit and rdata are registered and done is a one-cycle pulse
`timescale 1ns/1ps

module cacheController
	import cachePkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	// processor side
	input  logic   req,
	input  logic   we,
	input  addrT   addr,
	input  wordT   wdata,
	output logic   done,
	output logic   hit,
	output wordT   rdata,
	// metadata array
	input  wayT    hitWay,
	input  wayT    victimWay,
	output tagT    lookupTag,
	output indexT  index,
	output logic   touch,
	output logic   fill,
	// data array
	input  wordT   rdWord,
	output offsetT wordSel,
	output wayT    way,
	output logic   wrEn,
	output wordT   wrData,
	// memory side
	input  logic   memRdValid,
	input  wordT   memRdata,
	input  logic   memWrDone,
	output logic   memRead,
	output logic   memWrite,
	output addrT   memAddr,
	output wordT   memWdata
);

	ctrlStateT state, nextState;

	// latched request
	addrT addrQ;
	logic weQ;
	wordT wdataQ;

	logic missFlag; // access missed at first lookup
	wayT fillWay; // victim picked at the miss
	offsetT fillCnt; // next word to arrive from memory
	logic isHit;
	logic lastWord;

	assign lookupTag = addrQ[TagLsb +: TagW]; // bit 15 ignored
	assign index = addrQ[IndexLsb +: IndexW];
	assign isHit = |hitWay;
	assign lastWord = memRdValid && (fillCnt == offsetT'(WordsPerBlock - 1));

	// data array port takes the fill path in FillWait and the hit way otherwise
	assign wordSel = (state == FillWait) ? fillCnt : addrQ[OffsetW-1:0];
	assign way = (state == FillWait) ? fillWay : hitWay;
	assign wrData = (state == FillWait) ? memRdata : wdataQ;
	assign wrEn = ((state == FillWait) && memRdValid) ||
		((state == Compare) && weQ && isHit); // write hit updates the block

	// metadata strobes
	assign touch = (state == Compare) && isHit;
	assign fill = (state == FillMeta);

	// one-cycle memory strobes
	assign memRead = (state == FillReq);
	assign memWrite = (state == Compare) && weQ; // write through on hit and miss
	assign memAddr = weQ ? {1'b0, addrQ[AddrW-2:0]}
		: {1'b0, lookupTag, index, {OffsetW{1'b0}}}; // block base for fills
	assign memWdata = wdataQ;

	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (req) nextState = Compare;
			end
			Compare: begin
				if (weQ) begin
					nextState = WriteThru;
				end else if (isHit) begin
					nextState = Idle; // read done
				end else begin
					nextState = FillReq;
				end
			end
			FillReq: nextState = FillWait;
			FillWait: begin
				if (lastWord) nextState = FillMeta;
			end
			FillMeta: nextState = Compare; // retry now hits
			WriteThru: begin
				if (memWrDone) nextState = Idle;
			end
			default: nextState = Idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= Idle;
			done <= 1'b0;
			hit <= 1'b0;
			missFlag <= 1'b0;
			fillWay <= '0;
			fillCnt <= '0;
		end else begin
			state <= nextState;
			done <= 1'b0; // pulse by default
			case (state)
				Idle: begin
					if (req) missFlag <= 1'b0; // fresh access
				end
				Compare: begin
					if (!isHit) missFlag <= 1'b1;
					if (!weQ && isHit) begin
						done <= 1'b1;
						hit <= !missFlag; // refilled block reports a miss
					end
					if (!weQ && !isHit) fillWay <= victimWay;
				end
				FillReq: fillCnt <= '0;
				FillWait: begin
					if (memRdValid) fillCnt <= fillCnt + 1'b1;
				end
				WriteThru: begin
					if (memWrDone) begin
						done <= 1'b1; // one cycle after memWrDone
						hit <= !missFlag;
					end
				end
				default: ;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if ((state == Idle) && req) begin
			addrQ <= addr;
			weQ <= we;
			wdataQ <= wdata;
		end
		if ((state == Compare) && !weQ && isHit) begin
			rdata <= rdWord;
		end
	end

endmodule

//--- cachePkg.sv
// shared widths, geometry and types for the two-way set-associative cache
// word address layout: [15] unused, [14:9] tag, [8:3] set index, [2:0] word in block
// metadata byte per way: [7] valid, [6] lru, [5:0] tag
// each cache module pulls what it needs with a wildcard import
package cachePkg;

	// address fields
	localparam int AddrW = 16;
	localparam int TagW = 6;
	localparam int IndexW = 6;
	localparam int OffsetW = 3;
	localparam int TagLsb = 9; // tag starts above index
	localparam int IndexLsb = 3; // index starts above word offset

	localparam int WordW = 16;

	// geometry
	localparam int NumWays = 2;
	localparam int NumSets = 64;
	localparam int WordsPerBlock = 8;

	// metadata byte layout
	localparam int MetaW = 8;
	localparam int ValidBit = 7;
	localparam int LruBit = 6; // 1 = most recently used

	typedef logic [AddrW-1:0] addrT;
	typedef logic [TagW-1:0] tagT;
	typedef logic [IndexW-1:0] indexT;
	typedef logic [OffsetW-1:0] offsetT;
	typedef logic [WordW-1:0] wordT;
	typedef logic [NumWays-1:0] wayT; // one-hot, bit 1 = first way
	typedef logic [MetaW-1:0] metaT;

	// controller FSM
	typedef enum logic [2:0] {
		Idle,
		Compare,
		FillReq,
		FillWait,
		FillMeta,
		WriteThru
	} ctrlStateT;

endpackage

//--- cacheTop.sv
// top level of the two-way write-through cache
// processor port: req/we/addr/wdata in, done/hit/rdata out
// memory port: memRead/memWrite strobes with memAddr/memWdata,
// memRdValid per returned word, memWrDone once per write
// only wiring here, the controller runs the access sequence
`timescale 1ns/1ps

module cacheTop
	import cachePkg::*;
(
	input  logic clk,
	input  logic rstN,
	// processor port
	input  logic req,
	input  logic we,
	input  addrT addr,
	input  wordT wdata,
	output logic done,
	output logic hit,
	output wordT rdata,
	// memory port
	output logic memRead,
	output logic memWrite,
	output addrT memAddr,
	output wordT memWdata,
	input  logic memRdValid,
	input  wordT memRdata,
	input  logic memWrDone
);

	// controller to metadata array
	tagT lookupTag;
	indexT index;
	logic touch;
	logic fill;
	wayT hitWay;
	wayT victimWay;

	// controller to data array
	offsetT wordSel;
	wayT way;
	logic wrEn;
	wordT wrData;
	wordT rdWord;

	cacheController ctrl (
		.clk(clk), .rstN(rstN),
		.req(req), .we(we), .addr(addr), .wdata(wdata),
		.done(done), .hit(hit), .rdata(rdata),
		.hitWay(hitWay), .victimWay(victimWay),
		.lookupTag(lookupTag), .index(index), .touch(touch), .fill(fill),
		.rdWord(rdWord), .wordSel(wordSel), .way(way), .wrEn(wrEn), .wrData(wrData),
		.memRdValid(memRdValid), .memRdata(memRdata), .memWrDone(memWrDone),
		.memRead(memRead), .memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata)
	);

	metaDataArray meta (
		.clk(clk), .rstN(rstN),
		.index(index), .lookupTag(lookupTag),
		.touch(touch), .fill(fill),
		.hitWay(hitWay), .victimWay(victimWay)
	);

	dataArray data (
		.clk(clk),
		.index(index), .wordSel(wordSel), .way(way),
		.wrEn(wrEn), .wrData(wrData),
		.rdWord(rdWord)
	);

endmodule

//--- dataArray.sv
// block storage, two ways by 64 sets by 8 words of 16 bits
// one synchronous write port, one combinational read port
// both ports address the same way, set and word
// way is one-hot as in the metadata array; a zero way blocks the write
`timescale 1ns/1ps

module dataArray
	import cachePkg::*;
(
	input  logic   clk,
	input  indexT  index,
	input  offsetT wordSel, // word within the block
	input  wayT    way,
	input  logic   wrEn,
	input  wordT   wrData,
	output wordT   rdWord
);

	// [0] first way, [1] second way
	wordT dataMem [NumWays][NumSets][WordsPerBlock];

	logic wayIdx;

	// bit 0 of the one-hot select picks the second way
	assign wayIdx = way[0];

	always_ff @(posedge clk) begin
		if (wrEn && (|way)) begin
			dataMem[wayIdx][index][wordSel] <= wrData;
		end
	end

	// read follows address with no clock
	assign rdWord = dataMem[wayIdx][index][wordSel];

endmodule

//--- metaDataArray.sv
// valid/lru/tag storage for 64 sets of two ways with one byte per way
// hitWay and victimWay are combinational on index and lookupTag
// touch marks the hit way most recent
// fill installs lookupTag in the victim way
// both updates take effect at the next rising clk
`timescale 1ns/1ps

module metaDataArray
	import cachePkg::*;
(
	input  logic  clk,
	input  logic  rstN,
	input  indexT index,
	input  tagT   lookupTag,
	input  logic  touch, // hit way becomes most recent
	input  logic  fill, // write victim entry
	output wayT   hitWay,
	output wayT   victimWay
);

	// [1] first way and [0] second way as in wayT
	metaT [NumWays-1:0] metaMem [NumSets];

	metaT [NumWays-1:0] curSet; // entries of the addressed set
	wayT updWay; // way that becomes most recent
	logic updEn;

	assign curSet = metaMem[index];

	// only valid entries with a matching tag hit
	always_comb begin
		for (int w = 0; w < NumWays; w++) begin
			hitWay[w] = curSet[w][ValidBit] && (curSet[w][TagW-1:0] == lookupTag);
		end
	end

	// victim is an invalid first way, then an invalid second way, then the lru one
	always_comb begin
		if (!curSet[1][ValidBit]) begin
			victimWay = 2'b10;
		end else if (!curSet[0][ValidBit]) begin
			victimWay = 2'b01;
		end else if (!curSet[1][LruBit]) begin
			victimWay = 2'b10; // first way is older
		end else begin
			victimWay = 2'b01;
		end
	end

	assign updWay = fill ? victimWay : hitWay; // fill wins over touch
	assign updEn = fill | (touch & (|hitWay)); // touch on a miss does nothing

	always_ff @(posedge clk) begin
		if (!rstN) begin
			// clear valid and lru bits of every entry
			for (int s = 0; s < NumSets; s++) begin
				for (int w = 0; w < NumWays; w++) begin
					metaMem[s][w][ValidBit] <= 1'b0;
					metaMem[s][w][LruBit] <= 1'b0;
				end
			end
		end else if (updEn) begin
			for (int w = 0; w < NumWays; w++) begin
				if (updWay[w] && fill) begin
					metaMem[index][w] <= {1'b1, 1'b1, lookupTag}; // valid, mru, new tag
				end else if (updWay[w]) begin
					metaMem[index][w][LruBit] <= 1'b1;
				end else begin
					metaMem[index][w][LruBit] <= 1'b0; // other way now the older one
				end
			end
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# builds the cache testbench with Verilator and runs it
# exit status 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tbCache -o simCache
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/simCache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi

//--- tbCache.sv
// testbench for the two-way set-associative write-through cache
// memory model answers fills and write-throughs after 1 to 4 cycles of random delay
// reference tag/valid/lru model plus shadow memory predict hit flag and read data
// directed accesses first, then a random run over a few sets and tags
// run through run.sh, which builds with Verilator and checks the log
`timescale 1ns/1ps

module tbCache
	import cachePkg::*;
();

	localparam int ResetCycles = 5;
	localparam int RandomAccesses = 300;
	localparam int TotalAccesses = 320; // directed plus random, rounded up
	localparam int WorstAccessCycles = 50; // 8 words at up to 5 cycles, plus FSM steps
	localparam int TimeoutCycles = TotalAccesses * WorstAccessCycles + ResetCycles + 20;
	localparam int MemWords = 32768; // address bit 15 stays zero

	logic clk;
	logic rstN;
	logic req;
	logic we;
	addrT addr;
	wordT wdata;
	logic done;
	logic hit;
	wordT rdata;
	logic memRead;
	logic memWrite;
	addrT memAddr;
	wordT memWdata;
	logic memRdValid;
	wordT memRdata;
	logic memWrDone;

	wordT memArr [MemWords]; // memory model contents
	wordT shadowMem [MemWords]; // expected memory contents

	// reference metadata, way 0 = first way
	logic refValid [NumSets][2];
	tagT refTag [NumSets][2];
	logic refLru [NumSets][2];

	int errCount;
	int checkCount;
	int cycleCnt;
	logic [31:0] stimSeed;
	logic [31:0] delaySeed;

	cacheTop dut (
		.clk(clk), .rstN(rstN),
		.req(req), .we(we), .addr(addr), .wdata(wdata),
		.done(done), .hit(hit), .rdata(rdata),
		.memRead(memRead), .memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata),
		.memRdValid(memRdValid), .memRdata(memRdata), .memWrDone(memWrDone)
	);

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// start value of memory word i, mixes the whole address
	function automatic wordT fillPattern(input int i);
		logic [31:0] s;
		s = lcgNext(lcgNext(32'd29 + 32'(i)));
		return s[31:16] ^ wordT'(i);
	endfunction

	function automatic addrT makeAddr(input tagT t, input indexT s, input offsetT o);
		return {1'b0, t, s, o};
	endfunction

	// way holding tag t in set s, -1 if absent
	function automatic int refFindWay(input indexT s, input tagT t);
		int found;
		found = -1;
		for (int w = 1; w >= 0; w--) begin
			if (refValid[s][w] && (refTag[s][w] == t)) found = w;
		end
		return found;
	endfunction

	function automatic int refPickVictim(input indexT s);
		int v;
		if (!refValid[s][0]) v = 0; // empty first way first
		else if (!refValid[s][1]) v = 1;
		else if (!refLru[s][0]) v = 0; // first way is older
		else v = 1;
		return v;
	endfunction

	function automatic void refMakeRecent(input indexT s, input int w);
		refLru[s][w] = 1'b1;
		refLru[s][1 - w] = 1'b0;
	endfunction

	task automatic expectVal(input logic [31:0] got, input logic [31:0] exp,
		input string what, input addrT a);
		checkCount++;
		assert (got === exp) else begin
			errCount++;
			$display("error %0t ns: %s at address %h, got %h expected %h",
				$time, what, a, got, exp);
		end
	endtask

	// one access, checked against the reference model; wantHit < 0 skips the directed check
	task automatic accessAndCheck(input logic isWrite, input addrT a, input wordT wd,
		input int wantHit);
		indexT s;
		tagT t;
		int hitW;
		int vicW;
		logic expHit;
		wordT expData;
		int lat;
		s = a[IndexLsb +: IndexW];
		t = a[TagLsb +: TagW];
		hitW = refFindWay(s, t);
		expHit = (hitW >= 0);
		expData = shadowMem[a[14:0]];
		req <= 1'b1;
		we <= isWrite;
		addr <= a;
		wdata <= wd;
		@(posedge clk); // dut samples req here
		req <= 1'b0;
		lat = 0;
		while (done !== 1'b1) begin
			@(posedge clk);
			lat++; // cycles since the sampling edge
		end
		expectVal(32'(hit), 32'(expHit), "hit flag vs model", a);
		if (wantHit >= 0) expectVal(32'(hit), 32'(wantHit), "directed hit flag", a);
		if (isWrite) begin
			shadowMem[a[14:0]] = wd;
			expectVal(32'(memArr[a[14:0]]), 32'(wd), "memory word after write", a);
			if (expHit) refMakeRecent(s, hitW); // no allocation on a miss
		end else begin
			expectVal(32'(rdata), 32'(expData), "read data", a);
			if (expHit) begin
				expectVal(32'(lat), 32'd2, "read hit latency", a);
				refMakeRecent(s, hitW);
			end else begin
				vicW = refPickVictim(s);
				refValid[s][vicW] = 1'b1;
				refTag[s][vicW] = t;
				refMakeRecent(s, vicW);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		cycleCnt = 0;
		while (cycleCnt <= TimeoutCycles) begin
			@(posedge clk);
			cycleCnt++;
		end
		$display("timeout after %0d cycles, an access never finished", cycleCnt);
		$display("TB FAILED");
		$finish;
	end

	// memory model, one block fill or one write at a time
	initial begin : memModel
		addrT base;
		int delay;
		memRdValid = 1'b0;
		memRdata = '0;
		memWrDone = 1'b0;
		delaySeed = 32'd29;
		for (int i = 0; i < MemWords; i++) memArr[i] = fillPattern(i);
		forever begin
			@(posedge clk);
			if (memRead) begin
				base = memAddr; // block base word
				for (int k = 0; k < WordsPerBlock; k++) begin
					delaySeed = lcgNext(delaySeed);
					delay = 1 + int'(delaySeed[17:16]);
					repeat (delay) @(posedge clk);
					memRdValid <= 1'b1;
					memRdata <= memArr[base[14:0] + 15'(k)];
					@(posedge clk);
					memRdValid <= 1'b0;
				end
			end else if (memWrite) begin
				memArr[memAddr[14:0]] = memWdata;
				delaySeed = lcgNext(delaySeed);
				delay = 1 + int'(delaySeed[17:16]);
				repeat (delay) @(posedge clk);
				memWrDone <= 1'b1;
				@(posedge clk);
				memWrDone <= 1'b0;
			end
		end
	end

	initial begin
		tagT rt;
		indexT rs;
		offsetT ro;
		logic rw;
		rstN = 1'b0;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		errCount = 0;
		checkCount = 0;
		stimSeed = 32'd29;
		for (int i = 0; i < MemWords; i++) shadowMem[i] = fillPattern(i);
		for (int s = 0; s < NumSets; s++) begin
			for (int w = 0; w < 2; w++) begin
				refValid[s][w] = 1'b0;
				refTag[s][w] = '0;
				refLru[s][w] = 1'b0;
			end
		end
		repeat (ResetCycles) @(posedge clk);
		rstN <= 1'b1;

		// cold miss, then hit on the same word
		accessAndCheck(1'b0, makeAddr(6'd5, 6'd3, 3'd2), '0, 0);
		accessAndCheck(1'b0, makeAddr(6'd5, 6'd3, 3'd2), '0, 1);

		// three tags in set 7, lru decides who goes
		accessAndCheck(1'b0, makeAddr(6'd1, 6'd7, 3'd0), '0, 0);
		accessAndCheck(1'b0, makeAddr(6'd2, 6'd7, 3'd4), '0, 0);
		accessAndCheck(1'b0, makeAddr(6'd1, 6'd7, 3'd5), '0, 1); // tag 2 now oldest
		accessAndCheck(1'b0, makeAddr(6'd3, 6'd7, 3'd1), '0, 0); // evicts tag 2
		accessAndCheck(1'b0, makeAddr(6'd1, 6'd7, 3'd7), '0, 1);
		accessAndCheck(1'b0, makeAddr(6'd2, 6'd7, 3'd3), '0, 0); // evicts tag 3
		accessAndCheck(1'b0, makeAddr(6'd3, 6'd7, 3'd6), '0, 0); // evicts tag 1

		// write hit, then read back from the cache
		accessAndCheck(1'b1, makeAddr(6'd5, 6'd3, 3'd6), 16'hbeef, 1);
		accessAndCheck(1'b0, makeAddr(6'd5, 6'd3, 3'd6), '0, 1);

		// write miss does not allocate
		accessAndCheck(1'b1, makeAddr(6'd9, 6'd20, 3'd1), 16'h1234, 0);
		accessAndCheck(1'b0, makeAddr(6'd9, 6'd20, 3'd1), '0, 0);
		accessAndCheck(1'b0, makeAddr(6'd9, 6'd20, 3'd1), '0, 1);

		// random mix, four tags over sets 10 to 13
		for (int i = 0; i < RandomAccesses; i++) begin
			stimSeed = lcgNext(stimSeed);
			rt = tagT'(stimSeed[17:16]);
			rs = indexT'(stimSeed[19:18]) + 6'd10;
			ro = stimSeed[22:20];
			rw = (stimSeed[25:24] == 2'b00); // about one in four writes
			stimSeed = lcgNext(stimSeed);
			accessAndCheck(rw, makeAddr(rt, rs, ro), stimSeed[31:16], -1);
		end

		$display("checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
